// ==== Bender.yml ====
package:
  name: rtefi_rx

sources:
  - design/rtefi_rx_pkg.sv
  - design/addr_config_mem.sv
  - design/udp_port_cam.sv
  - design/rx_crc_check.sv
  - design/rx_pbuf_writer.sv
  - design/rx_scanner.sv
  - design/rtefi_rx.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/rtefi_rx_tb.sv

// ==== design/addr_config_mem.sv ====
// Own MAC and IP byte store, written from the config port and read combinationally by the scanner
`timescale 1ns/1ps
module addr_config_mem (
	input logic rx_clk,
	input logic arst_n,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic config_s,
	input logic [3:0] ip_a,
	output logic [7:0] ip_d
);
	import rtefi_rx_pkg::*;

	// Bytes 0..5 MAC first byte first, 6..9 IP, rest spare
	logic [0:15][7:0] cfg_mem;

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n)
			cfg_mem <= default_addr_image;
		else if (config_s)
			cfg_mem[config_a] <= config_d;
	end

	// No read register, the scanner compares in the same cycle
	assign ip_d = cfg_mem[ip_a];

endmodule

// ==== design/rtefi_rx.sv ====
// Receive engine top: registers the GMII inputs and connects scanner, tables, CRC check and writer
`timescale 1ns/1ps
module rtefi_rx (
	input logic rx_clk,
	input logic arst_n,
	input logic [7:0] rxd,
	input logic rx_dv,
	input logic rx_er,
	input logic enable_rx,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic config_s,
	input logic config_p,
	output logic [7:0] rx_mac_d,
	output logic [11:0] rx_mac_a,
	output logic rx_mac_wen,
	output rtefi_rx_pkg::rx_status_t rx_status,
	output logic rx_status_valid
);
	import rtefi_rx_pkg::*;

	rx_beat_t beat;
	logic [3:0] ip_a;
	logic [7:0] ip_d;
	logic [15:0] dst_port;
	logic port_chk, port_hit;
	logic [2:0] port_idx;
	logic in_frame, frame_end, crc_ok;
	rx_category_e verdict;
	logic [2:0] verdict_sel;

	// Boundary register so the pins can land in IOBs
	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n)
			beat <= '0;
		else
			beat <= '{data: rxd, dv: rx_dv, er: rx_er};
	end

	rx_scanner a_scan (
		.rx_clk, .arst_n, .beat, .enable_rx, .ip_d, .port_hit, .port_idx,
		.ip_a, .dst_port, .port_chk, .in_frame, .frame_end, .verdict, .verdict_sel
	);

	addr_config_mem b_addr (
		.rx_clk, .arst_n, .config_a, .config_d, .config_s, .ip_a, .ip_d
	);

	udp_port_cam c_port (
		.rx_clk, .arst_n, .config_a, .config_d, .config_p, .dst_port, .port_chk,
		.port_hit, .port_idx
	);

	rx_crc_check d_crc (
		.rx_clk, .arst_n, .beat, .in_frame, .frame_end, .crc_ok
	);

	// Adds the second cycle of latency on data and status
	rx_pbuf_writer e_write (
		.rx_clk, .arst_n, .beat, .in_frame, .frame_end, .verdict, .verdict_sel, .crc_ok,
		.rx_mac_d, .rx_mac_a, .rx_mac_wen, .rx_status, .rx_status_valid
	);

endmodule

// ==== design/rtefi_rx_pkg.sv ====
// Shared constants, enums and records for the receive engine; imported by every block that needs them
package rtefi_rx_pkg;

	// Buffer offset width, one bank holds 2**paw bytes
	localparam int paw = 11;
	localparam int n_udp_ports = 8;

	// Own addresses after reset, 12:55:55:00:01:2d and 192.168.7.4
	localparam logic [47:0] default_mac = 48'h12_55_55_00_01_2d;
	localparam logic [31:0] default_ip = {8'd192, 8'd168, 8'd7, 8'd4};
	// Address memory image, byte 0 in the top bits, bytes 10 to 15 unused
	localparam logic [127:0] default_addr_image = {default_mac, default_ip, 48'h0};

	// Port table defaults, entry 0 in the low bits; zero never matches
	localparam logic [n_udp_ports-1:0][15:0] default_udp_ports = {
		16'd0, 16'd0, 16'd0, 16'd0, 16'd803, 16'd802, 16'd801, 16'd7
	};

	// CRC-32 in MSB-first register form, bits fed LSB first
	localparam logic [31:0] crc_poly = 32'h04c1_1db7;
	localparam logic [31:0] crc_residue = 32'hc704_dd7b;

	// Framing and header byte values
	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte = 8'hd5;
	localparam logic [15:0] ethertype_ip = 16'h0800;
	localparam logic [15:0] ethertype_arp = 16'h0806;
	localparam logic [7:0] ipv4_ver_ihl = 8'h45;
	localparam logic [7:0] ip_proto_udp = 8'd17;

	// One registered GMII byte
	typedef struct packed {
		logic [7:0] data;
		logic dv;
		logic er;
	} rx_beat_t;

	typedef enum logic [1:0] {cat_other, cat_arp, cat_udp} rx_category_e;
	typedef enum logic [1:0] {st_idle, st_preamble, st_frame, st_skip} scan_state_e;

	// Per-frame record, 19 bits
	typedef struct packed {
		rx_category_e category;
		logic [2:0] udp_sel;
		logic [paw-1:0] pack_len;
		logic crc_ok;
		logic rx_err;
		logic bank;
	} rx_status_t;

endpackage

// ==== design/rx_crc_check.sv ====
// Ethernet FCS checker: runs CRC-32 over every in-frame byte and flags a good residue at frame end
`timescale 1ns/1ps
module rx_crc_check (
	input logic rx_clk,
	input logic arst_n,
	input rtefi_rx_pkg::rx_beat_t beat,
	input logic in_frame,
	input logic frame_end,
	output logic crc_ok
);
	import rtefi_rx_pkg::*;

	logic [31:0] crc_q;

	// One byte, LSB on the wire first, into a left-shifting register
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[31] ^ d[i];
			r = {r[30:0], 1'b0};
			if (fb)
				r = r ^ crc_poly;
		end
		return r;
	endfunction

	// Seeded with ones, reseeded once the frame is over
	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n)
			crc_q <= '1;
		else if (in_frame)
			crc_q <= crc_byte(crc_q, beat.data);
		else if (frame_end)
			crc_q <= '1;
	end

	// FCS included, so a clean frame leaves the fixed residue
	assign crc_ok = (crc_q == crc_residue);

endmodule

// ==== design/rx_pbuf_writer.sv ====
// Receive buffer writer: streams frame bytes into the current bank and emits one status per frame
`timescale 1ns/1ps
module rx_pbuf_writer (
	input logic rx_clk,
	input logic arst_n,
	input rtefi_rx_pkg::rx_beat_t beat,
	input logic in_frame,
	input logic frame_end,
	input rtefi_rx_pkg::rx_category_e verdict,
	input logic [2:0] verdict_sel,
	input logic crc_ok,
	output logic [7:0] rx_mac_d,
	output logic [11:0] rx_mac_a,
	output logic rx_mac_wen,
	output rtefi_rx_pkg::rx_status_t rx_status,
	output logic rx_status_valid
);
	import rtefi_rx_pkg::*;

	logic bank;
	// Write offset, doubles as the length at frame end
	logic [paw-1:0] len_cnt;
	logic err_q;

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			bank <= 1'b0;
			len_cnt <= '0;
			err_q <= 1'b0;
			rx_mac_wen <= 1'b0;
			rx_status_valid <= 1'b0;
		end else begin
			rx_mac_wen <= in_frame;
			rx_status_valid <= frame_end;
			if (in_frame) begin
				len_cnt <= len_cnt + 1'b1;
				if (beat.er)
					err_q <= 1'b1;
			end else if (frame_end) begin
				len_cnt <= '0;
				err_q <= 1'b0;
				// Keep an accepted frame, let a rejected one be overwritten
				if (verdict != cat_other && crc_ok)
					bank <= ~bank;
			end
		end
	end

	always_ff @(posedge rx_clk) begin
		rx_mac_d <= beat.data;
		rx_mac_a <= {bank, len_cnt};
		// Bank field is the one just written, before any flip
		if (frame_end)
			rx_status <= '{
				category: verdict,
				udp_sel: verdict_sel,
				pack_len: len_cnt,
				crc_ok: crc_ok,
				rx_err: err_q,
				bank: bank
			};
	end

endmodule

// ==== design/rx_scanner.sv ====
// Frame parser FSM: follows preamble and headers, drives address lookups and the frame verdict
`timescale 1ns/1ps
module rx_scanner (
	input logic rx_clk,
	input logic arst_n,
	input rtefi_rx_pkg::rx_beat_t beat,
	input logic enable_rx,
	input logic [7:0] ip_d,
	input logic port_hit,
	input logic [2:0] port_idx,
	output logic [3:0] ip_a,
	output logic [15:0] dst_port,
	output logic port_chk,
	output logic in_frame,
	output logic frame_end,
	output rtefi_rx_pkg::rx_category_e verdict,
	output logic [2:0] verdict_sel
);
	import rtefi_rx_pkg::*;

	scan_state_e state, state_nxt;
	// Byte index after D5, saturates well past the last checked header byte
	logic [5:0] hdr_cnt;
	logic [5:0] ofs_ip_dst, ofs_arp_tpa;
	// Running match flags, rearmed between frames
	logic mac_ok, bcast_ok, udp_ok, arp_ok, err_seen;

	assign in_frame = (state == st_frame) && beat.dv;
	assign frame_end = (state == st_frame) && !beat.dv;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:
				if (beat.dv) begin
					if (!enable_rx || (beat.data != preamble_byte && beat.data != sfd_byte))
						state_nxt = st_skip;
					else if (beat.data == sfd_byte)
						state_nxt = st_frame;
					else
						state_nxt = st_preamble;
				end
			st_preamble:
				if (!beat.dv)
					state_nxt = st_idle;
				else if (beat.data == sfd_byte)
					state_nxt = st_frame;
				else if (beat.data != preamble_byte)
					state_nxt = st_skip;
			// Frame and skip both end when dv drops
			default:
				if (!beat.dv)
					state_nxt = st_idle;
		endcase
	end

	// IP destination sits at bytes 30..33, ARP target IP at 38..41
	assign ofs_ip_dst = hdr_cnt - 6'd24;
	assign ofs_arp_tpa = hdr_cnt - 6'd32;

	// Point the address memory at the reference byte for this frame byte
	always_comb begin
		ip_a = 4'd0;
		if (hdr_cnt < 6'd6)
			ip_a = hdr_cnt[3:0];
		else if (hdr_cnt >= 6'd30 && hdr_cnt <= 6'd33)
			ip_a = ofs_ip_dst[3:0];
		else if (hdr_cnt >= 6'd38 && hdr_cnt <= 6'd41)
			ip_a = ofs_arp_tpa[3:0];
	end

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			hdr_cnt <= '0;
			port_chk <= 1'b0;
			{mac_ok, bcast_ok, udp_ok, arp_ok} <= 4'hf;
			err_seen <= 1'b0;
		end else begin
			state <= state_nxt;
			// Port bytes complete after byte 37, table answers a cycle later
			port_chk <= in_frame && (hdr_cnt == 6'd37);
			if (state == st_idle)
				err_seen <= beat.dv && beat.er;
			else if (beat.dv && beat.er)
				err_seen <= 1'b1;
			if (state != st_frame) begin
				hdr_cnt <= '0;
				{mac_ok, bcast_ok, udp_ok, arp_ok} <= 4'hf;
			end else if (beat.dv) begin
				if (hdr_cnt != 6'h3f)
					hdr_cnt <= hdr_cnt + 6'd1;
				// Destination MAC, own or broadcast
				if (hdr_cnt < 6'd6) begin
					if (beat.data != ip_d)
						mac_ok <= 1'b0;
					if (beat.data != 8'hff)
						bcast_ok <= 1'b0;
				end
				// Ethertype high then low byte
				if (hdr_cnt == 6'd12 && beat.data != ethertype_ip[15:8])
					{udp_ok, arp_ok} <= 2'b00;
				if (hdr_cnt == 6'd13) begin
					if (beat.data != ethertype_ip[7:0])
						udp_ok <= 1'b0;
					if (beat.data != ethertype_arp[7:0])
						arp_ok <= 1'b0;
				end
				// Plain 20-byte IPv4 header carrying UDP
				if (hdr_cnt == 6'd14 && beat.data != ipv4_ver_ihl)
					udp_ok <= 1'b0;
				if (hdr_cnt == 6'd23 && beat.data != ip_proto_udp)
					udp_ok <= 1'b0;
				if (hdr_cnt >= 6'd30 && hdr_cnt <= 6'd33 && beat.data != ip_d)
					udp_ok <= 1'b0;
				if (hdr_cnt >= 6'd38 && hdr_cnt <= 6'd41 && beat.data != ip_d)
					arp_ok <= 1'b0;
			end
		end
	end

	// UDP destination port, big endian
	always_ff @(posedge rx_clk) begin
		if (in_frame && hdr_cnt == 6'd36)
			dst_port[15:8] <= beat.data;
		if (in_frame && hdr_cnt == 6'd37)
			dst_port[7:0] <= beat.data;
	end

	// Both classes need all header bytes through 41, so the port answer has settled
	always_comb begin
		verdict = cat_other;
		verdict_sel = 3'd0;
		if (!err_seen && (mac_ok || bcast_ok) && hdr_cnt >= 6'd42) begin
			if (udp_ok && port_hit) begin
				verdict = cat_udp;
				verdict_sel = port_idx;
			end else if (arp_ok) begin
				verdict = cat_arp;
			end
		end
	end

endmodule

// ==== design/udp_port_cam.sv ====
// UDP port table with parallel compare; gives a registered hit and the lowest matching index
`timescale 1ns/1ps
module udp_port_cam (
	input logic rx_clk,
	input logic arst_n,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic config_p,
	input logic [15:0] dst_port,
	input logic port_chk,
	output logic port_hit,
	output logic [2:0] port_idx
);
	import rtefi_rx_pkg::*;

	logic [n_udp_ports-1:0][15:0] port_tbl;
	logic [n_udp_ports-1:0] hit_vec;
	logic [2:0] idx_nxt;

	// Even address is the high byte of entry config_a/2
	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n)
			port_tbl <= default_udp_ports;
		else if (config_p && !config_a[0])
			port_tbl[config_a[3:1]][15:8] <= config_d;
		else if (config_p)
			port_tbl[config_a[3:1]][7:0] <= config_d;
	end

	always_comb begin
		idx_nxt = 3'd0;
		// Empty entries hold zero and stay out of the compare
		for (int i = 0; i < n_udp_ports; i++)
			hit_vec[i] = (port_tbl[i] != 16'd0) && (port_tbl[i] == dst_port);
		// Walk down so the lowest index wins
		for (int i = n_udp_ports - 1; i >= 0; i--)
			if (hit_vec[i])
				idx_nxt = 3'(i);
	end

	// Result holds until the next check
	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			port_hit <= 1'b0;
			port_idx <= 3'd0;
		end else if (port_chk) begin
			port_hit <= |hit_vec;
			port_idx <= idx_nxt;
		end
	end

endmodule

// ==== flist.f ====
+incdir+verification
design/rtefi_rx_pkg.sv
design/addr_config_mem.sv
design/udp_port_cam.sv
design/rx_crc_check.sv
design/rx_pbuf_writer.sv
design/rx_scanner.sv
design/rtefi_rx.sv
verification/rtefi_rx_tb.sv

// ==== verification/rtefi_rx_frames.svh ====
// Frame builders and GMII driver that the receive testbench module includes
`ifndef RTEFI_RX_FRAMES_SVH
`define RTEFI_RX_FRAMES_SVH

// Appends the low n bytes of v with the most significant byte first
task automatic push_bytes(input logic [63:0] v, input int n);
	for (int i = n - 1; i >= 0; i--)
		frame_q.push_back(v[8*i +: 8]);
endtask

// Ethernet, 20-byte IPv4 and UDP headers followed by a random payload
task automatic build_udp(input logic [47:0] mac, input logic [31:0] ip, input logic [15:0] port);
	int n;
	frame_q.delete();
	n = 8 + ({$random(seed)} % 24);
	push_bytes(mac, 6);
	push_bytes(src_mac, 6);
	push_bytes(16'h0800, 2);
	// Version and IHL, TOS, total length
	push_bytes({8'h45, 8'h00, 16'(28 + n)}, 4);
	push_bytes(32'h1c46_4000, 4);
	// TTL, protocol 17, checksum left at zero
	push_bytes({8'h40, 8'd17, 16'h0000}, 4);
	push_bytes(src_ip, 4);
	push_bytes(ip, 4);
	// Source port, destination port, UDP length, checksum
	push_bytes({16'hc000, port, 16'(8 + n), 16'h0000}, 8);
	for (int i = 0; i < n; i++)
		frame_q.push_back(8'($random(seed)));
endtask

// ARP request for target IP tpa padded to minimum size
task automatic build_arp(input logic [47:0] mac, input logic [31:0] tpa);
	frame_q.delete();
	push_bytes(mac, 6);
	push_bytes(src_mac, 6);
	push_bytes(16'h0806, 2);
	push_bytes(64'h0001_0800_0604_0001, 8);
	push_bytes(src_mac, 6);
	push_bytes(src_ip, 4);
	push_bytes(48'h0, 6);
	push_bytes(tpa, 4);
	while (frame_q.size() < 60)
		frame_q.push_back(8'h00);
endtask

// Reflected CRC-32 over the queued bytes and complemented as sent on the wire
function automatic logic [31:0] fcs_of_frame();
	logic [31:0] c;
	c = 32'hffff_ffff;
	foreach (frame_q[i]) begin
		c = c ^ {24'h0, frame_q[i]};
		for (int b = 0; b < 8; b++)
			c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
	end
	return ~c;
endfunction

// FCS goes out low byte first
task automatic add_fcs(input logic corrupt);
	logic [31:0] fcs;
	fcs = fcs_of_frame();
	// One flipped bit breaks the residue
	if (corrupt)
		fcs[0] = ~fcs[0];
	for (int i = 0; i < 4; i++)
		frame_q.push_back(fcs[8*i +: 8]);
endtask

// Preamble, SFD and frame bytes
// rx_er is raised on byte er_pos and on none if er_pos is negative
task automatic drive_frame(input int er_pos);
	for (int i = 0; i < 8; i++) begin
		@(negedge rx_clk);
		rxd = (i == 7) ? 8'hd5 : 8'h55;
		rx_dv = 1'b1;
		rx_er = 1'b0;
	end
	foreach (frame_q[i]) begin
		@(negedge rx_clk);
		rxd = frame_q[i];
		rx_er = (i == er_pos);
		// Only a frame that starts while enabled reaches the buffer
		pin_frame = enable_rx;
	end
	@(negedge rx_clk);
	rxd = 8'h00;
	rx_dv = 1'b0;
	rx_er = 1'b0;
	pin_frame = 1'b0;
	dv_low_cyc = cyc;
endtask

`endif

// ==== verification/rtefi_rx_tb.sv ====
// Self-checking receive engine testbench that drives frames and checks buffer writes and status
`timescale 1ns/1ps
module rtefi_rx_tb;
	import rtefi_rx_pkg::*;

	// Twice the cycles of about fifteen frames under 100 bytes plus gaps
	localparam int max_cycles = 4000;

	logic rx_clk, arst_n;
	logic [7:0] rxd;
	logic rx_dv, rx_er, enable_rx;
	logic [3:0] config_a;
	logic [7:0] config_d;
	logic config_s, config_p;
	logic [7:0] rx_mac_d;
	logic [11:0] rx_mac_a;
	logic rx_mac_wen;
	rx_status_t rx_status;
	logic rx_status_valid;

	int seed = 32'h728f3711;
	int cyc = 0;
	int dv_low_cyc = 0;
	int wen_cnt = 0;
	int status_cnt = 0;
	int status_cyc = 0;
	// Bank the next frame should land in
	logic exp_bank;
	rx_status_t last_status;
	logic [7:0] frame_q[$];
	logic [7:0] buf_mem [0:4095];
	// High while the GMII driver puts a frame byte on the pins
	logic pin_frame = 1'b0;
	// Frame flag and pin byte at the last two rising edges
	logic [8:0] pin_d1 = 9'h0;
	logic [8:0] pin_d2 = 9'h0;
	// Own addresses as currently configured and the far end addresses
	logic [47:0] own_mac = 48'h12_55_55_00_01_2d;
	logic [31:0] own_ip = {8'd192, 8'd168, 8'd7, 8'd4};
	logic [47:0] src_mac = 48'h02_00_00_00_00_01;
	logic [31:0] src_ip = {8'd192, 8'd168, 8'd7, 8'd1};

	`include "rtefi_rx_frames.svh"

	rtefi_rx dut0 (
		.rx_clk, .arst_n, .rxd, .rx_dv, .rx_er, .enable_rx,
		.config_a, .config_d, .config_s, .config_p,
		.rx_mac_d, .rx_mac_a, .rx_mac_wen, .rx_status, .rx_status_valid
	);

	task automatic end_with_failure(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		end_with_failure($sformatf("mismatch at %0t ns: %s", $time, msg));
	endtask

	initial begin
		rx_clk = 1'b0;
		forever #10 rx_clk = ~rx_clk;
	end

	always @(posedge rx_clk) begin
		cyc++;
		if (cyc >= max_cycles)
			end_with_failure($sformatf("timeout: run did not finish in %0d cycles", max_cycles));
	end

	// Pin history for the two-cycle write latency
	always @(posedge rx_clk) begin
		pin_d2 = pin_d1;
		pin_d1 = {pin_frame, rxd};
	end

	// Buffer model and status capture on the falling edge
	always @(negedge rx_clk) begin
		// Every frame byte reaches the buffer port two cycles after the pins
		assert (rx_mac_wen == pin_d2[8]) else
			report_mismatch($sformatf("write strobe %b, expected %b", rx_mac_wen, pin_d2[8]));
		if (rx_mac_wen)
			assert (rx_mac_d == pin_d2[7:0]) else
				report_mismatch($sformatf("write data %h, expected pin byte %h",
					rx_mac_d, pin_d2[7:0]));
		if (rx_mac_wen) begin
			assert (rx_mac_a == {exp_bank, 11'(wen_cnt)}) else
				report_mismatch($sformatf("write address %h, expected %h",
					rx_mac_a, {exp_bank, 11'(wen_cnt)}));
			buf_mem[rx_mac_a] = rx_mac_d;
			wen_cnt++;
		end
		if (rx_status_valid) begin
			last_status = rx_status;
			status_cyc = cyc;
			status_cnt++;
		end
	end

	// One config write, address memory or port table
	task automatic write_config(input logic port_sel, input logic [3:0] a, input logic [7:0] d);
		@(negedge rx_clk);
		config_a = a;
		config_d = d;
		config_s = !port_sel;
		config_p = port_sel;
		@(negedge rx_clk);
		config_s = 1'b0;
		config_p = 1'b0;
	endtask

	// Sends the built frame and checks status, latency and buffered bytes
	task automatic check_frame(input rx_category_e cat, input logic [2:0] sel,
			input logic corrupt, input int er_pos);
		rx_status_t exp;
		int sent;
		add_fcs(corrupt);
		// Length counts every byte after D5 with the FCS
		exp = '{category: cat, udp_sel: sel, pack_len: 11'(frame_q.size()),
			crc_ok: !corrupt, rx_err: (er_pos >= 0), bank: exp_bank};
		sent = status_cnt;
		wen_cnt = 0;
		drive_frame(er_pos);
		wait (status_cnt != sent);
		assert (status_cyc == dv_low_cyc + 2) else
			report_mismatch($sformatf("status %0d cycles after dv low, expected 2",
				status_cyc - dv_low_cyc));
		assert (last_status == exp) else
			report_mismatch($sformatf("status %h, expected %h", last_status, exp));
		assert (wen_cnt == frame_q.size()) else
			report_mismatch($sformatf("%0d bytes written, expected %0d", wen_cnt, frame_q.size()));
		foreach (frame_q[i])
			assert (buf_mem[{exp_bank, 11'(i)}] == frame_q[i]) else
				report_mismatch($sformatf("buffer byte %0d is %h, expected %h",
					i, buf_mem[{exp_bank, 11'(i)}], frame_q[i]));
		// An accepted frame is kept and the next one goes to the other bank
		if (cat != cat_other && !corrupt)
			exp_bank = ~exp_bank;
		repeat (6) @(negedge rx_clk);
	endtask

	// Frame sent with reception disabled must leave no trace
	task automatic expect_no_traffic();
		int sent;
		add_fcs(1'b0);
		sent = status_cnt;
		wen_cnt = 0;
		enable_rx = 1'b0;
		drive_frame(-1);
		repeat (8) @(negedge rx_clk);
		enable_rx = 1'b1;
		assert (wen_cnt == 0 && status_cnt == sent) else
			report_mismatch($sformatf("disabled frame gave %0d writes and %0d status",
				wen_cnt, status_cnt - sent));
	endtask

	initial begin
		rxd = 8'h00;
		rx_dv = 1'b0;
		rx_er = 1'b0;
		enable_rx = 1'b1;
		config_a = 4'd0;
		config_d = 8'h00;
		config_s = 1'b0;
		config_p = 1'b0;
		exp_bank = 1'b0;
		arst_n = 1'b0;
		repeat (10) @(negedge rx_clk);
		arst_n = 1'b1;
		repeat (4) @(negedge rx_clk);
		// Good UDP to port 801 and the next frame in bank 1
		build_udp(own_mac, own_ip, 16'd801);
		check_frame(cat_udp, 3'd1, 1'b0, -1);
		build_udp(own_mac, own_ip, 16'd801);
		check_frame(cat_udp, 3'd1, 1'b1, -1);
		// Error flagged mid-header
		build_udp(own_mac, own_ip, 16'd802);
		check_frame(cat_other, 3'd0, 1'b0, 20);
		// Unlisted port, wrong IP, foreign MAC
		build_udp(own_mac, own_ip, 16'd1234);
		check_frame(cat_other, 3'd0, 1'b0, -1);
		build_udp(own_mac, {8'd192, 8'd168, 8'd7, 8'd5}, 16'd801);
		check_frame(cat_other, 3'd0, 1'b0, -1);
		build_udp(48'h02_11_22_33_44_55, own_ip, 16'd801);
		check_frame(cat_other, 3'd0, 1'b0, -1);
		build_udp(48'hffff_ffff_ffff, own_ip, 16'd7);
		check_frame(cat_udp, 3'd0, 1'b0, -1);
		// ARP for us and for someone else
		build_arp(48'hffff_ffff_ffff, own_ip);
		check_frame(cat_arp, 3'd0, 1'b0, -1);
		build_arp(48'hffff_ffff_ffff, {8'd192, 8'd168, 8'd7, 8'd99});
		check_frame(cat_other, 3'd0, 1'b0, -1);
		// Entry 2 becomes port 900 (0x0384)
		write_config(1'b1, 4'd4, 8'h03);
		write_config(1'b1, 4'd5, 8'h84);
		build_udp(own_mac, own_ip, 16'd900);
		check_frame(cat_udp, 3'd2, 1'b0, -1);
		build_udp(own_mac, own_ip, 16'd802);
		check_frame(cat_other, 3'd0, 1'b0, -1);
		// Last IP byte moves from 4 to 9
		write_config(1'b0, 4'd9, 8'd9);
		build_udp(own_mac, own_ip, 16'd801);
		check_frame(cat_other, 3'd0, 1'b0, -1);
		own_ip[7:0] = 8'd9;
		build_udp(own_mac, own_ip, 16'd801);
		check_frame(cat_udp, 3'd1, 1'b0, -1);
		build_udp(own_mac, own_ip, 16'd803);
		expect_no_traffic();
		// Reception works again once re-enabled
		build_udp(own_mac, own_ip, 16'd803);
		check_frame(cat_udp, 3'd3, 1'b0, -1);
		if (status_cnt == 14) begin
			$display("Verification passed");
			$finish;
		end else
			report_mismatch($sformatf("%0d status records, expected 14", status_cnt));
	end

endmodule
